// ==== src/fhe_param_pkg.sv ====
`default_nettype none

// arithmetic and timing constants of the key-switching accumulator
package fhe_param_pkg;

  // coefficient and key word width
  localparam int FSIZE = 64;

  // stages of the 64x64 multiplier pipe
  localparam int MULT_CYCLES = 4;

  // beat in to sum out inside elem_lazy
  // multiplier, low add, high add with carry
  localparam int ELEM_LATENCY = MULT_CYCLES + 2;

  // one slot per pipeline position
  // a sum comes back just as the ring returns to its slot
  localparam int ACC_SLOTS = ELEM_LATENCY;

  // slot index width
  localparam int SLOT_W = $clog2(ACC_SLOTS);

endpackage

`default_nettype wire

// ==== src/fhe_word_pkg.sv ====
`default_nettype none

// data formats of the wide accumulator
package fhe_word_pkg;

  // 128-bit sum split into two machine words
  // hi sits on top, so the struct lines up with the full value
  typedef struct packed {
    logic [fhe_param_pkg::FSIZE-1:0] hi;
    logic [fhe_param_pkg::FSIZE-1:0] lo;
  } wide_half_t;

  // one accumulator word, two readings of the same bits
  // full for the plain unsigned 128-bit value
  // half for the lo/hi pair the lazy adder works on
  typedef union packed {
    logic [2*fhe_param_pkg::FSIZE-1:0] full;
    wide_half_t                        half;
  } wide_word_u;

endpackage

`default_nettype wire

// ==== src/delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

// fixed-latency shift register
// dout follows din by DEPTH cycles
module delay_line #(
  parameter int WIDTH = 1,
  parameter int DEPTH = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  // negative depth has no meaning
  if (DEPTH < 0) begin : g_depth_chk
    $error("delay_line: DEPTH must not be negative, got %0d", DEPTH);
  end

  if (DEPTH == 0) begin : g_bypass
    // zero depth, straight through
    assign dout = din;
  end else begin : g_shift
    // stage 0 takes din, last stage drives dout
    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= din;
        // shift one position per cycle
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign dout = stage_q[DEPTH-1];
  end

endmodule

`default_nettype wire

// ==== src/pipe_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

// unsigned WIDTH x WIDTH multiplier, STAGES cycles from a/b to prod
// operand register, then STAGES-1 product registers for retiming
module pipe_mult #(
  parameter int WIDTH  = 64,
  parameter int STAGES = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  logic [WIDTH-1:0]     a,
  input  logic [WIDTH-1:0]     b,
  output logic                 out_valid,
  output logic [2*WIDTH-1:0]   prod
);

  if (STAGES < 1) begin : g_stage_chk
    $error("pipe_mult: STAGES must be at least 1, got %0d", STAGES);
  end

  logic [WIDTH-1:0]   a_q;
  logic [WIDTH-1:0]   b_q;
  logic [2*WIDTH-1:0] mult_s;
  logic [STAGES-1:0]  vld_q;

  // operand capture, first stage
  always_ff @(posedge clk) begin
    a_q <= a;
    b_q <= b;
  end

  // full-width product of the captured operands
  assign mult_s = a_q * b_q;

  // valid walks beside the data, one bit per stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= in_valid;
      for (int i = 1; i < STAGES; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  if (STAGES == 1) begin : g_no_pipe
    // single stage, product leaves straight after the operand register
    assign prod = mult_s;
  end else begin : g_prod_pipe
    logic [2*WIDTH-1:0] prod_q [STAGES-1];

    always_ff @(posedge clk) begin
      prod_q[0] <= mult_s;
      for (int i = 1; i < STAGES - 1; i++) begin
        prod_q[i] <= prod_q[i-1];
      end
    end

    assign prod = prod_q[STAGES-2];
  end

  assign out_valid = vld_q[STAGES-1];

  // valid comes out exactly STAGES cycles after it went in
  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n, STAGES) |-> (out_valid == $past(in_valid, STAGES)))
    else $error("pipe_mult: out_valid does not match in_valid %0d cycles back", STAGES);

endmodule

`default_nettype wire

// ==== src/elem_lazy.sv ====
`timescale 1ns/1ps
`default_nettype none

// one lazy accumulate step of the key-switching inner product
// {out2, out1} = {op2, op1} + op3 * op4, mod 2^128, no reduction
module elem_lazy
  import fhe_param_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             in_last,
  // running sum lo
  input  logic [FSIZE-1:0] op1,
  // running sum hi
  input  logic [FSIZE-1:0] op2,
  // key word
  input  logic [FSIZE-1:0] op3,
  // decomposed coefficient
  input  logic [FSIZE-1:0] op4,
  // new sum lo
  output logic [FSIZE-1:0] out1,
  // new sum hi
  output logic [FSIZE-1:0] out2,
  output logic             out_valid,
  output logic             out_last
);

  logic                 mult_valid;
  logic [2*FSIZE-1:0]   prod;
  logic [FSIZE-1:0]     op1_d;
  logic [FSIZE-1:0]     op2_d;
  logic [FSIZE-1:0]     prod_hi_d;
  logic [FSIZE:0]       lo_sum;
  logic [FSIZE:0]       lo_sum_q;
  logic [FSIZE-1:0]     hi_sum;
  logic [2*FSIZE-1:0]   res_q;

  // key x coeff, MULT_CYCLES
  pipe_mult #(.WIDTH(FSIZE), .STAGES(MULT_CYCLES)) u_mult (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (op3),
    .b        (op4),
    .out_valid(mult_valid),
    .prod     (prod)
  );

  // sum lo meets the product as it leaves the multiplier
  delay_line #(.WIDTH(FSIZE), .DEPTH(MULT_CYCLES)) u_op1_dly (
    .clk(clk), .rst_n(rst_n), .din(op1), .dout(op1_d)
  );

  // sum hi is needed one stage later, with the carry
  delay_line #(.WIDTH(FSIZE), .DEPTH(MULT_CYCLES + 1)) u_op2_dly (
    .clk(clk), .rst_n(rst_n), .din(op2), .dout(op2_d)
  );

  // stage 1: low halves, 65 bits to keep the carry
  assign lo_sum = {1'b0, prod[FSIZE-1:0]} + {1'b0, op1_d};

  delay_line #(.WIDTH(FSIZE + 1), .DEPTH(1)) u_lo_dly (
    .clk(clk), .rst_n(rst_n), .din(lo_sum), .dout(lo_sum_q)
  );

  // product hi waits for the low carry
  delay_line #(.WIDTH(FSIZE), .DEPTH(1)) u_prod_hi_dly (
    .clk(clk), .rst_n(rst_n), .din(prod[2*FSIZE-1:FSIZE]), .dout(prod_hi_d)
  );

  // stage 2: high halves plus carry, top carry dropped (wraps at 2^128)
  assign hi_sum = prod_hi_d + op2_d + {{(FSIZE-1){1'b0}}, lo_sum_q[FSIZE]};

  delay_line #(.WIDTH(2 * FSIZE), .DEPTH(1)) u_res_dly (
    .clk(clk), .rst_n(rst_n), .din({hi_sum, lo_sum_q[FSIZE-1:0]}), .dout(res_q)
  );

  assign out1 = res_q[FSIZE-1:0];
  assign out2 = res_q[2*FSIZE-1:FSIZE];

  // valid follows the multiplier through both adder stages
  delay_line #(.WIDTH(1), .DEPTH(2)) u_valid_dly (
    .clk(clk), .rst_n(rst_n), .din(mult_valid), .dout(out_valid)
  );

  // last skips the multiplier, so it takes the whole latency here
  delay_line #(.WIDTH(1), .DEPTH(ELEM_LATENCY)) u_last_dly (
    .clk(clk), .rst_n(rst_n), .din(in_last), .dout(out_last)
  );

  // the two chains must stay aligned
  a_last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_last |-> out_valid)
    else $error("elem_lazy: out_last without out_valid");

endmodule

`default_nettype wire

// ==== src/acc_ring.sv ====
`timescale 1ns/1ps
`default_nettype none

// slot ring around elem_lazy
// one wide sum per pipeline slot, fed back one latency later
module acc_ring
  import fhe_param_pkg::*, fhe_word_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic              in_first,
  input  logic              in_last,
  input  logic [FSIZE-1:0]  key,
  input  logic [FSIZE-1:0]  coeff,
  // toward elem_lazy
  output logic              e_valid,
  output logic              e_last,
  output logic [FSIZE-1:0]  e_lo,
  output logic [FSIZE-1:0]  e_hi,
  output logic [FSIZE-1:0]  e_key,
  output logic [FSIZE-1:0]  e_coeff,
  // back from elem_lazy
  input  logic [FSIZE-1:0]  e_out_lo,
  input  logic [FSIZE-1:0]  e_out_hi,
  input  logic              e_out_valid,
  input  logic              e_out_last,
  // finished sums
  output logic              res_valid,
  output logic [SLOT_W-1:0] res_slot,
  output wide_word_u        res_word
);

  logic [SLOT_W-1:0] slot_q;
  wide_word_u        bank_q [ACC_SLOTS];
  wide_word_u        wb_word;
  wide_word_u        src_word;

  // free-running slot pointer, beats or not
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_q <= '0;
    end else if (slot_q == SLOT_W'(ACC_SLOTS - 1)) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_q + 1'b1;
    end
  end

  // returning sum, tagged implicitly by slot_q
  always_comb begin
    wb_word.half.hi = e_out_hi;
    wb_word.half.lo = e_out_lo;
  end

  // sum bank, one entry per slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ACC_SLOTS; i++) begin
        bank_q[i] <= '0;
      end
    end else if (e_out_valid) begin
      bank_q[slot_q].half.hi <= e_out_hi;
      bank_q[slot_q].half.lo <= e_out_lo;
    end
  end

  always_comb begin
    // bank write happens at the edge, so a same-cycle write-back is taken directly
    src_word = e_out_valid ? wb_word : bank_q[slot_q];
    // first beat of a slot starts from zero
    if (in_first) begin
      src_word = '0;
    end
  end

  assign e_valid = in_valid;
  assign e_last  = in_valid && in_last;
  assign e_lo    = src_word.half.lo;
  assign e_hi    = src_word.half.hi;
  assign e_key   = key;
  assign e_coeff = coeff;

  // result strobe, one cycle behind elem_lazy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= e_out_valid && e_out_last;
    end
  end

  // result payload held until the next finished sum
  always_ff @(posedge clk) begin
    if (e_out_valid && e_out_last) begin
      res_slot <= slot_q;
      res_word <= wb_word;
    end
  end

  // first and last only mean something on a beat
  a_first_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    in_first |-> in_valid)
    else $error("acc_ring: in_first high without in_valid");

  a_last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    in_last |-> in_valid)
    else $error("acc_ring: in_last high without in_valid");

endmodule

`default_nettype wire

// ==== src/fhe_acc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// key-switching inner-product accumulator
// beat with in_last in cycle t gives res_valid in t + ELEM_LATENCY + 1
module fhe_acc_top
  import fhe_param_pkg::*, fhe_word_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic              in_first,
  input  logic              in_last,
  input  logic [FSIZE-1:0]  key,
  input  logic [FSIZE-1:0]  coeff,
  output logic              res_valid,
  output logic [SLOT_W-1:0] res_slot,
  output wide_word_u        res_word
);

  // ring to pipe
  logic             e_valid;
  logic             e_last;
  logic [FSIZE-1:0] e_lo;
  logic [FSIZE-1:0] e_hi;
  logic [FSIZE-1:0] e_key;
  logic [FSIZE-1:0] e_coeff;
  // pipe to ring
  logic [FSIZE-1:0] e_out_lo;
  logic [FSIZE-1:0] e_out_hi;
  logic             e_out_valid;
  logic             e_out_last;

  acc_ring u_acc_ring (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_first   (in_first),
    .in_last    (in_last),
    .key        (key),
    .coeff      (coeff),
    .e_valid    (e_valid),
    .e_last     (e_last),
    .e_lo       (e_lo),
    .e_hi       (e_hi),
    .e_key      (e_key),
    .e_coeff    (e_coeff),
    .e_out_lo   (e_out_lo),
    .e_out_hi   (e_out_hi),
    .e_out_valid(e_out_valid),
    .e_out_last (e_out_last),
    .res_valid  (res_valid),
    .res_slot   (res_slot),
    .res_word   (res_word)
  );

  elem_lazy u_elem_lazy (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (e_valid),
    .in_last  (e_last),
    .op1      (e_lo),
    .op2      (e_hi),
    .op3      (e_key),
    .op4      (e_coeff),
    .out1     (e_out_lo),
    .out2     (e_out_hi),
    .out_valid(e_out_valid),
    .out_last (e_out_last)
  );

endmodule

`default_nettype wire

// ==== tb/acc_model.svh ====
`ifndef ACC_MODEL_SVH
`define ACC_MODEL_SVH

// slot accumulator model, mirrors the ring counter from reset release
// per-slot running sum, wraps mod 2^128
logic [2*FSIZE-1:0] model_sum  [ACC_SLOTS];
// slot has seen a first and no last yet
bit                 model_open [ACC_SLOTS];
// ring position of the current cycle
int unsigned        model_slot;

// expected results, oldest first
int unsigned        exp_due  [$];
int unsigned        exp_slot [$];
logic [2*FSIZE-1:0] exp_word [$];

// bank cleared, ring back at slot 0
function automatic void model_reset();
  for (int i = 0; i < ACC_SLOTS; i++) begin
    model_sum[i]  = '0;
    model_open[i] = 1'b0;
  end
  model_slot = 0;
endfunction

// one beat into the current slot, now is the cycle of the beat
function automatic void model_beat(input bit first, input bit last,
                                   input logic [FSIZE-1:0] k,
                                   input logic [FSIZE-1:0] c,
                                   input int unsigned now);
  logic [2*FSIZE-1:0] prod;
  // widen before multiplying, full 128-bit product
  prod = {{FSIZE{1'b0}}, k} * {{FSIZE{1'b0}}, c};
  if (first) begin
    model_sum[model_slot] = '0;
  end
  // carry out of bit 127 dropped
  model_sum[model_slot] = model_sum[model_slot] + prod;
  model_open[model_slot] = 1'b1;
  if (last) begin
    // pipe latency plus the result register
    exp_due.push_back(now + ELEM_LATENCY + 1);
    exp_slot.push_back(model_slot);
    exp_word.push_back(model_sum[model_slot]);
    model_open[model_slot] = 1'b0;
  end
endfunction

// ring advances every cycle, beat or not
function automatic void model_step();
  model_slot = (model_slot + 1) % ACC_SLOTS;
endfunction

`endif

// ==== tb/tb_fhe_acc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fhe_acc_top
  import fhe_param_pkg::*, fhe_word_pkg::*;
();

  localparam int RESET_CYCLES    = 16;
  localparam int IDLE_CYCLES     = 12;
  // single beat with its wait, then four ring turns
  localparam int DIRECTED_CYCLES = 1 + ELEM_LATENCY + 2 + 4 * ACC_SLOTS;
  localparam int RAND_CYCLES     = 2000;
  localparam int DRAIN_CYCLES    = ELEM_LATENCY + 4;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + IDLE_CYCLES + DIRECTED_CYCLES +
                                   RAND_CYCLES + DRAIN_CYCLES + 16;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              in_first;
  logic              in_last;
  logic [FSIZE-1:0]  key;
  logic [FSIZE-1:0]  coeff;
  logic              res_valid;
  logic [SLOT_W-1:0] res_slot;
  wide_word_u        res_word;

  // edges since time zero
  int unsigned       cyc = 0;

  `include "acc_model.svh"

  fhe_acc_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_first (in_first),
    .in_last  (in_last),
    .key      (key),
    .coeff    (coeff),
    .res_valid(res_valid),
    .res_slot (res_slot),
    .res_word (res_word)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  // run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // mix of full random, all ones and small values
  function automatic logic [FSIZE-1:0] pick_operand();
    int unsigned sel;
    sel = $urandom_range(0, 9);
    if (sel < 2) begin
      return '1;
    end else if (sel < 4) begin
      return FSIZE'($urandom_range(0, 15));
    end else begin
      return FSIZE'({$urandom(), $urandom()});
    end
  endfunction

  // outputs are registered, stable 1 ns after the edge
  task automatic check_outputs();
    bit due;
    due = (exp_due.size() > 0) && (exp_due[0] == cyc);
    assert (res_valid === due)
      else abort_run($sformatf("error: res_valid got 0x%h expected 0x%h", res_valid, due));
    if (due) begin
      assert (res_slot === SLOT_W'(exp_slot[0]))
        else abort_run($sformatf("error: res_slot got 0x%h expected 0x%h",
                                 res_slot, exp_slot[0]));
      assert (res_word.full === exp_word[0])
        else abort_run($sformatf("error: res_word.full got 0x%h expected 0x%h",
                                 res_word.full, exp_word[0]));
      void'(exp_due.pop_front());
      void'(exp_slot.pop_front());
      void'(exp_word.pop_front());
    end
  endtask

  // wait for the edge, check, then leave room for the new drive
  task automatic step_cycle();
    @(posedge clk);
    #1;
    check_outputs();
  endtask

  // drive one cycle and tell the model; first forced on a closed slot
  task automatic drive_beat(input bit v, input bit f, input bit l,
                            input logic [FSIZE-1:0] k, input logic [FSIZE-1:0] c);
    bit f_eff;
    f_eff    = f || !model_open[model_slot];
    in_valid = v;
    in_first = v && f_eff;
    in_last  = v && l;
    key      = k;
    coeff    = c;
    if (v) begin
      model_beat(f_eff, l, k, c, cyc);
    end
    model_step();
  endtask

  // no beat, operand buses still toggle
  task automatic drive_idle();
    drive_beat(1'b0, 1'b0, 1'b0, pick_operand(), pick_operand());
  endtask

  initial begin
    void'($urandom(32'h0327_bcf7));
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_first = 1'b0;
    in_last  = 1'b0;
    key      = '0;
    coeff    = '0;
    model_reset();

    repeat (RESET_CYCLES) step_cycle();
    // ring sits at slot 0 in the release cycle
    rst_n = 1'b1;
    drive_idle();

    // quiet after reset, res_valid must stay low
    repeat (IDLE_CYCLES - 1) begin
      step_cycle();
      drive_idle();
    end

    // lone beat, first and last together
    step_cycle();
    drive_beat(1'b1, 1'b1, 1'b1, 64'hdead_beef_0123_4567, 64'h0000_0001_f00d_cafe);
    repeat (ELEM_LATENCY + 2) begin
      step_cycle();
      drive_idle();
    end

    // two slots over four ring turns, idle gaps in between
    // slot a: all ones every turn, carry into hi and wrap at 2^128
    // slot b: restarted by first in turn 2
    for (int t = 0; t < 4; t++) begin
      for (int s = 0; s < ACC_SLOTS; s++) begin
        step_cycle();
        if (s == 0) begin
          drive_beat(1'b1, t == 0, t == 3, '1, '1);
        end else if (s == 3) begin
          drive_beat(1'b1, t == 0 || t == 2, t == 3, pick_operand(), pick_operand());
        end else begin
          drive_idle();
        end
      end
    end

    // random beats, about 70% valid and 25% last
    repeat (RAND_CYCLES) begin
      step_cycle();
      drive_beat($urandom_range(0, 99) < 70, $urandom_range(0, 99) < 15,
                 $urandom_range(0, 99) < 25, pick_operand(), pick_operand());
    end

    // let the pipe empty
    repeat (DRAIN_CYCLES) begin
      step_cycle();
      drive_idle();
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
src/fhe_param_pkg.sv
src/fhe_word_pkg.sv
src/delay_line.sv
src/pipe_mult.sv
src/elem_lazy.sv
src/acc_ring.sv
src/fhe_acc_top.sv
tb/tb_fhe_acc_top.sv

// ==== Bender.yml ====
package:
  name: fhe_acc

sources:
  - files:
      - src/fhe_param_pkg.sv
      - src/fhe_word_pkg.sv
      - src/delay_line.sv
      - src/pipe_mult.sv
      - src/elem_lazy.sv
      - src/acc_ring.sv
      - src/fhe_acc_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_fhe_acc_top.sv
